/* filelist.f */
+incdir+design
design/key_types_pkg.sv
design/display_types_pkg.sv
design/key_sync.sv
design/key_debounce.sv
design/key_event_queue.sv
design/hex_display.sv
design/panel_input_top.sv
testbench/tb_panel_input.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the panel input testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f \
	--top-module tb_panel_input -o sim_panel_input \
	|| { echo "build failed"; exit 1; }

out="$(./obj_dir/sim_panel_input)"
echo "$out"
echo "$out" | grep -qF '** PASS **' && exit 0 || exit 1

/* testbench/tb_panel_input.sv */
`include "panel_config.svh"

module tb_panel_input;
	timeunit 1ns;
	timeprecision 1ps;

	import key_types_pkg::*;
	import display_types_pkg::*;

	localparam int NUM_ROWS = 9;
	localparam int TIMEOUT = 500;
	localparam int QUIET = 40;

	// active-low digit patterns with segment a in bit 0
	localparam seg_t SEG_TABLE [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02,
		7'h78, 7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};

	logic     clk;
	logic     rst;
	key_vec_t key_n;
	logic     credit_return;
	logic     evt_valid;
	key_idx_t evt_key;
	seg_t     hex0;
	seg_t     hex1;
	seg_t     hex2;

	// stimulus table with one row per test
	key_vec_t row_mask [NUM_ROWS];
	int       row_hold [NUM_ROWS];
	logic     row_bounce [NUM_ROWS];
	int       row_withhold [NUM_ROWS];
	int       row_exp_n [NUM_ROWS];
	key_idx_t row_exp [NUM_ROWS][4];

	key_idx_t    got [$];
	key_idx_t    model_last;
	evt_count_t  model_count;
	logic        disp_due;
	int          owed;
	int          withhold_left;
	int          errors;
	int          tests_failed;
	int unsigned lcg_state;

	panel_input_top UUT (
		.i_clk           (clk),
		.i_rst           (rst),
		.i_key_n         (key_n),
		.i_credit_return (credit_return),
		.o_evt_valid     (evt_valid),
		.o_evt_key       (evt_key),
		.o_hex0          (hex0),
		.o_hex1          (hex1),
		.o_hex2          (hex2)
	);

	always #5 clk = ~clk;

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return (lcg_state >> 16) & 32'h7fff;
	endfunction

	task automatic check_key(input string name, input key_idx_t actual, input key_idx_t expected);
		if (actual !== expected) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic check_seg(input string name, input seg_t actual, input seg_t expected);
		if (actual !== expected) begin
			$display("Fail %s: got 0x%h, expected 0x%h", name, actual, expected);
			errors++;
		end
	endtask

	task automatic check_display();
		check_seg("o_hex0", hex0, SEG_TABLE[hex_digit_t'({2'b00, model_last})]);
		check_seg("o_hex1", hex1, SEG_TABLE[model_count[3:0]]);
		check_seg("o_hex2", hex2, SEG_TABLE[model_count[7:4]]);
	endtask

	// sample at the falling edge and play the game side for one cycle
	task automatic tick();
		@(negedge clk);
		credit_return = 1'b0;
		if (disp_due)
			check_display();
		disp_due = evt_valid;
		if (evt_valid) begin
			got.push_back(evt_key);
			model_last = evt_key;
			model_count = model_count + evt_count_t'(1);
			owed++;
			if (owed > `EVT_CREDITS) begin
				$display("event delivered with no credit left, %0d outstanding", owed);
				errors++;
			end
		end
		if (withhold_left > 0)
			withhold_left--;
		else if (owed > 0) begin
			credit_return = 1'b1;
			owed--;
		end
	endtask

	// short presses well below the debounce window
	task automatic glitch_train(input key_vec_t mask);
		int n;
		n = 3 + int'(lcg_next() % 3);
		repeat (n) begin
			key_n = ~mask;
			repeat (1 + int'(lcg_next() % (`DEBOUNCE_CYCLES - 4))) tick();
			key_n = '1;
			repeat (1 + int'(lcg_next() % 4)) tick();
		end
	endtask

	task automatic run_row(input int r);
		int wait_cycles;
		int errors_before;
		errors_before = errors;
		got.delete();
		if (row_bounce[r])
			glitch_train(row_mask[r]);
		// credits are held back from the start of the real press
		withhold_left = row_withhold[r];
		if (row_hold[r] > 0) begin
			key_n = ~row_mask[r];
			repeat (row_hold[r]) tick();
			if (row_bounce[r])
				glitch_train(row_mask[r]);
		end
		key_n = '1;
		wait_cycles = 0;
		while ((got.size() < row_exp_n[r] || owed > 0 || withhold_left > 0)
			&& wait_cycles < TIMEOUT) begin
			tick();
			wait_cycles++;
		end
		if (got.size() < row_exp_n[r] || owed > 0 || withhold_left > 0) begin
			$display("test %0d: timed out waiting for events or credits", r + 1);
			errors++;
		end
		// late or extra events would show up here
		repeat (QUIET) tick();
		if (got.size() != row_exp_n[r]) begin
			$display("test %0d: expected %0d events but %0d arrived", r + 1, row_exp_n[r],
				got.size());
			errors++;
		end
		for (int i = 0; i < got.size() && i < row_exp_n[r]; i++)
			check_key("o_evt_key", got[i], row_exp[r][i]);
		if (errors == errors_before)
			$display("test %0d: ok, %0d events", r + 1, got.size());
		else begin
			$display("test %0d: failed", r + 1);
			tests_failed++;
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		key_n = '1;
		credit_return = 1'b0;
		model_last = '0;
		model_count = '0;
		disp_due = 1'b0;
		owed = 0;
		withhold_left = 0;
		errors = 0;
		tests_failed = 0;
		lcg_state = 46;

		// singles, glitch only, bounced press, groups, withheld credits
		row_mask = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0110, 4'b0100, 4'b1111,
			4'b1011, 4'b1111};
		row_hold = '{30, 30, 30, 30, 0, 30, 30, 30, 30};
		row_bounce = '{0, 0, 0, 0, 1, 1, 0, 0, 1};
		row_withhold = '{0, 0, 0, 0, 0, 0, 0, 80, 80};
		row_exp_n = '{1, 1, 1, 1, 0, 1, 4, 3, 4};
		row_exp = '{'{0, 0, 0, 0}, '{1, 0, 0, 0}, '{2, 0, 0, 0}, '{3, 0, 0, 0},
			'{0, 0, 0, 0}, '{2, 0, 0, 0}, '{0, 1, 2, 3}, '{0, 1, 3, 0}, '{0, 1, 2, 3}};

		repeat (4) tick();
		rst = 1'b0;

		// nothing may arrive while idle after reset
		repeat (QUIET) tick();
		check_display();
		if (got.size() != 0) begin
			$display("test 0: events arrived with no key pressed");
			errors++;
		end
		if (errors == 0)
			$display("test 0: ok, idle after reset");
		else begin
			$display("test 0: failed");
			tests_failed++;
		end

		for (int r = 0; r < NUM_ROWS; r++)
			run_row(r);

		$display("tests run %0d, tests failed %0d, errors %0d", NUM_ROWS + 1, tests_failed,
			errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

/* design/panel_input_top.sv */
`include "panel_config.svh"

module panel_input_top (
	input  logic                     i_clk,
	input  logic                     i_rst,
	input  key_types_pkg::key_vec_t  i_key_n,
	input  logic                     i_credit_return,
	output logic                     o_evt_valid,
	output key_types_pkg::key_idx_t  o_evt_key,
	output display_types_pkg::seg_t  o_hex0,
	output display_types_pkg::seg_t  o_hex1,
	output display_types_pkg::seg_t  o_hex2
);
	import key_types_pkg::*;

	key_vec_t key_level;
	key_vec_t key_press;

	key_sync sync0 (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_key_n (i_key_n),
		.o_level (key_level)
	);

	// one debouncer per key, stable level not needed here
	genvar g;
	for (g = 0; g < `NUM_KEYS; g++) begin : g_deb
		key_debounce deb (
			.i_clk    (i_clk),
			.i_rst    (i_rst),
			.i_level  (key_level[g]),
			.o_stable (),
			.o_press  (key_press[g])
		);
	end

	key_event_queue queue0 (
		.i_clk           (i_clk),
		.i_rst           (i_rst),
		.i_press         (key_press),
		.i_credit_return (i_credit_return),
		.o_evt_valid     (o_evt_valid),
		.o_evt_key       (o_evt_key)
	);

	hex_display disp0 (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_evt_valid (o_evt_valid),
		.i_evt_key   (o_evt_key),
		.o_hex0      (o_hex0),
		.o_hex1      (o_hex1),
		.o_hex2      (o_hex2)
	);

endmodule

/* design/hex_display.sv */
`include "panel_config.svh"

module hex_display (
	input  logic                     i_clk,
	input  logic                     i_rst,
	input  logic                     i_evt_valid,
	input  key_types_pkg::key_idx_t  i_evt_key,
	output display_types_pkg::seg_t  o_hex0,
	output display_types_pkg::seg_t  o_hex1,
	output display_types_pkg::seg_t  o_hex2
);
	import key_types_pkg::*;
	import display_types_pkg::*;

	key_idx_t   last_key;
	evt_count_t evt_count;

	// active-low, segment a in bit 0
	function automatic seg_t hex_to_seg(input hex_digit_t digit);
		case (digit)
			4'h0:    hex_to_seg = 7'b1000000;
			4'h1:    hex_to_seg = 7'b1111001;
			4'h2:    hex_to_seg = 7'b0100100;
			4'h3:    hex_to_seg = 7'b0110000;
			4'h4:    hex_to_seg = 7'b0011001;
			4'h5:    hex_to_seg = 7'b0010010;
			4'h6:    hex_to_seg = 7'b0000010;
			4'h7:    hex_to_seg = 7'b1111000;
			4'h8:    hex_to_seg = 7'b0000000;
			4'h9:    hex_to_seg = 7'b0010000;
			4'ha:    hex_to_seg = 7'b0001000;
			4'hb:    hex_to_seg = 7'b0000011;
			4'hc:    hex_to_seg = 7'b1000110;
			4'hd:    hex_to_seg = 7'b0100001;
			4'he:    hex_to_seg = 7'b0000110;
			default: hex_to_seg = 7'b0001110;
		endcase
	endfunction

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			last_key  <= '0;
			evt_count <= '0;
		end
		else if (i_evt_valid) begin
			last_key  <= i_evt_key;
			evt_count <= evt_count + evt_count_t'(1);
		end
	end

	// key index on hex0, count nibbles on hex2/hex1
	assign o_hex0 = hex_to_seg(hex_digit_t'({2'b00, last_key}));
	assign o_hex1 = hex_to_seg(evt_count[3:0]);
	assign o_hex2 = hex_to_seg(evt_count[7:4]);

endmodule

/* design/key_event_queue.sv */
`include "panel_config.svh"

module key_event_queue (
	input  logic                     i_clk,
	input  logic                     i_rst,
	input  key_types_pkg::key_vec_t  i_press,
	input  logic                     i_credit_return,
	output logic                     o_evt_valid,
	output key_types_pkg::key_idx_t  o_evt_key
);
	import key_types_pkg::*;

	localparam int PTR_W = $clog2(`EVT_FIFO_DEPTH);
	localparam credit_t MAX_CREDITS = credit_t'(`EVT_CREDITS);

	q_state_t         state;
	key_vec_t         pending;
	key_vec_t         clr_mask;
	key_vec_t         pending_left;
	key_idx_t         sel_idx;
	logic             sel_found;
	key_idx_t         fifo_mem [`EVT_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   fill;
	credit_t          credits;
	logic             fifo_full;
	logic             fifo_empty;
	logic             push;
	logic             pop;

	// lowest pending index wins, so scan from the top down
	always_comb begin
		sel_idx   = '0;
		sel_found = 1'b0;
		for (int i = `NUM_KEYS - 1; i >= 0; i--) begin
			if (pending[i]) begin
				sel_idx   = key_idx_t'(i);
				sel_found = 1'b1;
			end
		end
	end

	assign fifo_full    = (fill == (PTR_W+1)'(`EVT_FIFO_DEPTH));
	assign fifo_empty   = (fill == '0);
	assign push         = (state == scan) && sel_found && !fifo_full;
	assign pop          = !fifo_empty && (credits != '0);
	assign clr_mask     = push ? (key_vec_t'(1) << sel_idx) : '0;
	assign pending_left = pending & ~clr_mask;

	// pending bits and scanner
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			state   <= idle;
			pending <= '0;
		end
		else begin
			// a repeat press of a pending key just merges
			pending <= pending_left | i_press;
			case (state)
				idle:    if (|pending) state <= scan;
				scan:    if (~|pending_left) state <= idle;
				default: state <= idle;
			endcase
		end
	end

	// circular FIFO control
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fill   <= '0;
		end
		else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   fill <= fill + 1'b1;
				2'b01:   fill <= fill - 1'b1;
				default: fill <= fill;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (push)
			fifo_mem[wr_ptr] <= sel_idx;
	end

	// credits, spend and return may coincide
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			credits <= MAX_CREDITS;
		end
		else if (pop && !i_credit_return) begin
			credits <= credits - credit_t'(1);
		end
		else if (!pop && i_credit_return && (credits < MAX_CREDITS)) begin
			credits <= credits + credit_t'(1);
		end
	end

	// event leaves the cycle after pop
	always_ff @(posedge i_clk) begin
		if (i_rst)
			o_evt_valid <= 1'b0;
		else
			o_evt_valid <= pop;
	end

	always_ff @(posedge i_clk) begin
		if (pop)
			o_evt_key <= fifo_mem[rd_ptr];
	end

endmodule

/* design/key_debounce.sv */
`include "panel_config.svh"

module key_debounce (
	input  logic i_clk,
	input  logic i_rst,
	input  logic i_level,
	output logic o_stable,
	output logic o_press
);
	import key_types_pkg::*;

	localparam deb_count_t LAST_COUNT = deb_count_t'(`DEBOUNCE_CYCLES - 1);

	deb_count_t cnt;
	logic       stable;
	logic       differs;

	assign differs = (i_level != stable);

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			stable  <= 1'b0;
			cnt     <= '0;
			o_press <= 1'b0;
		end
		else begin
			o_press <= 1'b0;
			if (differs) begin
				if (cnt == LAST_COUNT) begin
					// held long enough, accept the new level
					stable  <= i_level;
					cnt     <= '0;
					o_press <= i_level;
				end
				else begin
					cnt <= cnt + deb_count_t'(1);
				end
			end
			else begin
				// any agreeing cycle restarts the window
				cnt <= '0;
			end
		end
	end

	assign o_stable = stable;

endmodule

/* design/key_sync.sv */
`include "panel_config.svh"

module key_sync (
	input  logic                     i_clk,
	input  logic                     i_rst,
	input  key_types_pkg::key_vec_t  i_key_n,
	output key_types_pkg::key_vec_t  o_level
);
	import key_types_pkg::*;

	key_vec_t sync_q1;
	key_vec_t sync_q2;

	// keys are active low on the board, flip to pressed = 1 at the first stage
	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
		end
		else begin
			sync_q1 <= ~i_key_n;
			sync_q2 <= sync_q1;
		end
	end

	assign o_level = sync_q2;

endmodule

/* design/display_types_pkg.sv */
`include "panel_config.svh"

package display_types_pkg;

	// one hex digit
	typedef logic [3:0] hex_digit_t;

	// active-low segments, bit 0 is segment a, bit 6 is segment g
	typedef logic [6:0] seg_t;

	// delivered events, wraps
	typedef logic [`EVT_COUNT_W-1:0] evt_count_t;

endpackage

/* design/key_types_pkg.sv */
`include "panel_config.svh"

package key_types_pkg;

	// one bit per key
	typedef logic [`NUM_KEYS-1:0] key_vec_t;

	// index of a single key
	typedef logic [$clog2(`NUM_KEYS)-1:0] key_idx_t;

	// debounce counter, must hold DEBOUNCE_CYCLES
	typedef logic [$clog2(`DEBOUNCE_CYCLES+1)-1:0] deb_count_t;

	// credits available toward the game
	typedef logic [`CREDIT_W-1:0] credit_t;

	// pending scanner of the event queue
	typedef enum logic {
		idle,
		scan
	} q_state_t;

endpackage

/* design/panel_config.svh */
`ifndef PANEL_CONFIG_SVH
`define PANEL_CONFIG_SVH

// number of push keys on the panel
`define NUM_KEYS 4

// consecutive cycles of disagreement before the stable level flips
// around 250000 at 25 MHz on the board, short for simulation
`define DEBOUNCE_CYCLES 16

// key event FIFO entries, power of two
`define EVT_FIFO_DEPTH 4

// credits held by the queue after reset
`define EVT_CREDITS 2

// width of the credit counter
`define CREDIT_W 3

// width of the delivered event count
`define EVT_COUNT_W 8

`endif
